// ==== all.f ====
logic/cache_pkg.sv
logic/line_buffer.sv
logic/cache_ctrl.sv
logic/ap_data_cache.sv
sim/cache_asserts.sv
sim/cache_checker.sv
sim/tb_ap_data_cache.sv

// ==== run.sh ====
#!/bin/sh
rm -f sim.log
{ verilator --binary --timing --assert -f all.f --top-module tb_ap_data_cache -o sim_tb &&
  ./obj_dir/sim_tb +verilator+error+limit+100 ; } > sim.log 2>&1
grep -q "Test failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Test passed" sim.log || { echo "no pass result in sim.log"; exit 1; }
echo "simulation ok"

// ==== sim/tb_ap_data_cache.sv ====
module tb_ap_data_cache;
    timeunit 1ns;
    timeprecision 100ps;

    import cache_pkg::*;

    localparam int NUM_TESTS   = 13;
    localparam int MEM_WORDS   = 256;
    localparam int CYCLE_LIMIT = NUM_TESTS * 80;
    localparam logic [15:0] SEED = 16'd57776;

    logic       clk = 1'b0;
    logic       rst = 1'b0;
    cache_cmd_t cmd = CMD_IDLE;
    row_addr_t  row_addr = '0;
    col_sel_t   col_sel = '0;
    word_t      row_wdata = '0;
    col_vec_t   col_wdata = '0;
    logic       ready;
    word_t      row_rdata;
    col_vec_t   col_rdata;
    logic       rd_req;
    ddr_addr_t  rd_addr;
    logic       rd_valid = 1'b0;
    word_t      rd_data = '0;
    logic       wr_req;
    ddr_addr_t  wr_addr;
    word_t      wr_data;
    logic       wr_data_req = 1'b0;

    // DDR contents, its power-up image, and the words the processor should see.
    word_t mem [MEM_WORDS];
    word_t ddr_init [MEM_WORDS];
    word_t img [MEM_WORDS];

    cache_cmd_t t_cmd [NUM_TESTS];
    row_addr_t  t_addr [NUM_TESTS];
    col_sel_t   t_col [NUM_TESTS];
    word_t      t_wdata [NUM_TESTS];
    word_t      t_exp [NUM_TESTS];
    ddr_addr_t  t_wb_addr [NUM_TESTS];
    int         t_rd [NUM_TESTS];
    int         t_wr [NUM_TESTS];
    int         t_lat [NUM_TESTS];
    int         n_entries = 0;

    word_t     exp_data = '0;
    ddr_addr_t exp_rd_addr = '0;
    ddr_addr_t exp_wr_addr = '0;
    int        exp_rd = 0;
    int        exp_wr = 0;
    int        exp_lat = 0;
    int        tests;
    int        errors;
    int        total_errors = 0;
    int        cycle_cnt = 0;

    logic [15:0] gap_lfsr = SEED;
    logic [7:0]  rd_base = '0;
    logic [7:0]  rd_pos = '0;
    int          rd_wait = 0;
    int          rd_left = 0;
    logic        held = 1'b0;
    logic [7:0]  wr_base = '0;
    logic [7:0]  wr_pos = '0;
    int          wr_left = 0;

    always #2 clk = ~clk;

    ap_data_cache ap_data_cache_inst (.*);

    cache_checker cache_checker_inst (.*);

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic col_vec_t column_of(input row_addr_t base, input col_sel_t c);
        col_vec_t v;
        for (int j = 0; j < BLOCK_ROWS; j++)
            v[j] = img[8'(base + row_addr_t'(j))][c];
        return v;
    endfunction

    // base is the window tag that the command lands in.
    task automatic add_entry(input cache_cmd_t c, input row_addr_t addr, input row_addr_t base,
                             input col_sel_t sel, input word_t wdata, input int rd,
                             input int wr, input row_addr_t wb_tag, input int lat);
        t_cmd[n_entries] = c;
        t_addr[n_entries] = addr;
        t_col[n_entries] = sel;
        t_wdata[n_entries] = wdata;
        t_rd[n_entries] = rd;
        t_wr[n_entries] = wr;
        t_lat[n_entries] = lat;
        t_wb_addr[n_entries] = ddr_addr_t'(wb_tag) << 3;
        t_exp[n_entries] = '0;
        if (c == CMD_ROW_LOAD)
            t_exp[n_entries] = img[addr[7:0]];
        if (c == CMD_COL_LOAD)
            t_exp[n_entries] = column_of(base, sel);
        if (c == CMD_ROW_STORE)
            img[addr[7:0]] = wdata;
        if (c == CMD_COL_STORE)
            for (int j = 0; j < BLOCK_ROWS; j++)
                img[8'(base + row_addr_t'(j))][sel] = wdata[j];
        n_entries++;
    endtask

    task automatic build_table();
        logic [15:0] s;
        s = SEED;
        for (int w = 0; w < MEM_WORDS; w++)
        begin
            for (int b = 0; b < 16; b++)
            begin
                ddr_init[w][b] = s[0];
                s = lfsr_next(s);
            end
            img[w] = ddr_init[w];
        end
        add_entry(CMD_ROW_LOAD, 16'h20, 16'h20, 4'd0, 16'h0, 1, 0, 16'h0, 0);
        add_entry(CMD_ROW_LOAD, 16'h25, 16'h20, 4'd0, 16'h0, 0, 0, 16'h0, 2);
        add_entry(CMD_ROW_STORE, 16'h23, 16'h20, 4'd0, 16'hA5C3, 0, 0, 16'h0, 2);
        add_entry(CMD_ROW_LOAD, 16'h23, 16'h20, 4'd0, 16'h0, 0, 0, 16'h0, 2);
        add_entry(CMD_COL_STORE, 16'h20, 16'h20, 4'd5, 16'h3C96, 0, 0, 16'h0, 2);
        add_entry(CMD_COL_LOAD, 16'h20, 16'h20, 4'd5, 16'h0, 0, 0, 16'h0, 2);
        add_entry(CMD_ROW_LOAD, 16'h27, 16'h20, 4'd0, 16'h0, 0, 0, 16'h0, 2);
        add_entry(CMD_ROW_LOAD, 16'h60, 16'h60, 4'd0, 16'h0, 1, 1, 16'h20, 0);
        add_entry(CMD_ROW_LOAD, 16'h23, 16'h23, 4'd0, 16'h0, 1, 0, 16'h0, 0);
        add_entry(CMD_ROW_STORE, 16'h24, 16'h23, 4'd0, 16'h0F0F, 0, 0, 16'h0, 2);
        add_entry(CMD_FLUSH, 16'h23, 16'h23, 4'd0, 16'h0, 0, 1, 16'h23, 0);
        add_entry(CMD_FLUSH, 16'h23, 16'h23, 4'd0, 16'h0, 0, 0, 16'h0, 2);
        add_entry(CMD_COL_LOAD, 16'h2A, 16'h23, 4'd5, 16'h0, 0, 0, 16'h0, 2);
    endtask

    // the DDR model answers reads after 3 cycles and paces writes by wr_data_req.
    always @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            for (int w = 0; w < MEM_WORDS; w++)
                mem[w] <= ddr_init[w];
            rd_valid <= 1'b0;
            rd_left <= 0;
            rd_wait <= 0;
            wr_left <= 0;
            wr_data_req <= 1'b0;
        end
        else
        begin
            rd_valid <= 1'b0;
            wr_data_req <= 1'b0;
            if (rd_req)
            begin
                rd_base <= rd_addr[10:3];
                rd_pos <= '0;
                rd_wait <= 3;
                rd_left <= BLOCK_ROWS;
            end
            else if (rd_wait > 0)
                rd_wait <= rd_wait - 1;
            else if (rd_left > 0)
            begin
                if (rd_pos[1:0] == 2'd3 && !held)
                    gap_lfsr <= lfsr_next(gap_lfsr);
                if (rd_pos[1:0] == 2'd3 && !held && gap_lfsr[0])
                    held <= 1'b1;
                else
                begin
                    rd_valid <= 1'b1;
                    rd_data <= mem[rd_base + rd_pos];
                    rd_pos <= rd_pos + 8'd1;
                    rd_left <= rd_left - 1;
                    held <= 1'b0;
                end
            end
            if (wr_req)
            begin
                wr_base <= wr_addr[10:3];
                wr_pos <= '0;
                wr_left <= BLOCK_ROWS;
            end
            else if (wr_left > 0)
            begin
                wr_data_req <= 1'b1;
                wr_left <= wr_left - 1;
            end
            if (wr_data_req)
            begin
                mem[wr_base + wr_pos] <= wr_data;
                wr_pos <= wr_pos + 8'd1;
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            $display("timeout after %0d cycles, %0d tests finished", cycle_cnt, tests);
            $display("Test failed");
            $finish;
        end
    end

    initial
    begin
        build_table();
        repeat (3) @(posedge clk);
        rst <= 1'b1;
        repeat (4) @(posedge clk);
        for (int i = 0; i < NUM_TESTS; i++)
        begin
            cmd <= t_cmd[i];
            row_addr <= t_addr[i];
            col_sel <= t_col[i];
            row_wdata <= t_wdata[i];
            col_wdata <= t_wdata[i];
            exp_data <= t_exp[i];
            exp_rd_addr <= ddr_addr_t'(t_addr[i]) << 3;
            exp_wr_addr <= t_wb_addr[i];
            exp_rd <= t_rd[i];
            exp_wr <= t_wr[i];
            exp_lat <= t_lat[i];
            @(posedge clk);
            while (ready !== 1'b1)
                @(posedge clk);
        end
        cmd <= CMD_IDLE;
        repeat (4) @(posedge clk);
        total_errors = errors + ap_data_cache_inst.cache_asserts_inst.fail_count;
        $display("%0d tests run, %0d errors", tests, total_errors);
        if (total_errors == 0 && tests == NUM_TESTS)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== sim/cache_checker.sv ====
module cache_checker
(
    input  logic                  clk,
    input  logic                  rst,
    input  cache_pkg::cache_cmd_t cmd,
    input  logic                  ready,
    input  cache_pkg::word_t      row_rdata,
    input  cache_pkg::col_vec_t   col_rdata,
    input  logic                  rd_req,
    input  cache_pkg::ddr_addr_t  rd_addr,
    input  logic                  wr_req,
    input  cache_pkg::ddr_addr_t  wr_addr,
    input  cache_pkg::word_t      exp_data,
    input  cache_pkg::ddr_addr_t  exp_rd_addr,
    input  cache_pkg::ddr_addr_t  exp_wr_addr,
    input  int                    exp_rd,
    input  int                    exp_wr,
    input  int                    exp_lat,
    output int                    tests,
    output int                    errors
);
    timeunit 1ns;
    timeprecision 100ps;

    import cache_pkg::*;

    int   rd_seen = 0;
    int   wr_seen = 0;
    int   cycles = 0;
    int   test_errors = 0;
    logic started = 1'b0;

    initial
    begin
        tests = 0;
        errors = 0;
    end

    task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        test_errors++;
    endtask

    always @(posedge clk)
    begin
        if (rst)
        begin
            if (!started && (ready || rd_req || wr_req))
            begin
                $display("strobe seen at %0t ns before the first command", $time);
                test_errors++;
            end
            if (cmd != CMD_IDLE)
                started = 1'b1;
            if (rd_req)
            begin
                rd_seen++;
                if (rd_addr !== exp_rd_addr)
                    report_value("rd_addr", 32'(exp_rd_addr), 32'(rd_addr));
            end
            if (wr_req)
            begin
                wr_seen++;
                if (wr_addr !== exp_wr_addr)
                    report_value("wr_addr", 32'(exp_wr_addr), 32'(wr_addr));
            end
            if (ready)
            begin
                // cycles counts the sampling edge too.
                if (exp_lat != 0 && cycles - 1 != exp_lat)
                begin
                    $display("ready came %0d cycles after the command, not %0d", cycles - 1, exp_lat);
                    test_errors++;
                end
                if (cmd == CMD_ROW_LOAD && row_rdata !== exp_data)
                    report_value("row_rdata", 32'(exp_data), 32'(row_rdata));
                if (cmd == CMD_COL_LOAD && col_rdata !== exp_data)
                    report_value("col_rdata", 32'(exp_data), 32'(col_rdata));
                if (rd_seen != exp_rd || wr_seen != exp_wr)
                begin
                    $display("%0d read and %0d write bursts, expected %0d and %0d",
                             rd_seen, wr_seen, exp_rd, exp_wr);
                    test_errors++;
                end
                $display("test %0d cmd %0d: %s", tests, cmd, (test_errors == 0) ? "ok" : "wrong");
                tests++;
                errors += test_errors;
                test_errors = 0;
                rd_seen = 0;
                wr_seen = 0;
                cycles = 0;
            end
            else if (cmd != CMD_IDLE)
                cycles++;
        end
    end

endmodule

// ==== sim/cache_asserts.sv ====
module cache_asserts
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   ready,
    input  logic                   rd_req,
    input  logic                   wr_req,
    input  cache_pkg::ctrl_state_t state
);
    timeunit 1ns;
    timeprecision 100ps;

    import cache_pkg::*;

    int fail_count = 0;

    ready_pulse: assert property (@(posedge clk) disable iff (!rst) ready |=> !ready)
    else
    begin
        fail_count++;
        $error("ready high for more than one cycle");
    end

    rd_pulse: assert property (@(posedge clk) disable iff (!rst) rd_req |=> !rd_req)
    else
    begin
        fail_count++;
        $error("rd_req high for more than one cycle");
    end

    wr_pulse: assert property (@(posedge clk) disable iff (!rst) wr_req |=> !wr_req)
    else
    begin
        fail_count++;
        $error("wr_req high for more than one cycle");
    end

    no_overlap: assert property (@(posedge clk) disable iff (!rst) !(rd_req && wr_req))
    else
    begin
        fail_count++;
        $error("rd_req and wr_req high together");
    end

    reset_state: assert property (@(posedge clk) $rose(rst) |-> state == ST_IDLE)
    else
    begin
        fail_count++;
        $error("FSM not idle after reset");
    end

endmodule

bind ap_data_cache cache_asserts cache_asserts_inst
(
    .clk    (clk),
    .rst    (rst),
    .ready  (ready),
    .rd_req (rd_req),
    .wr_req (wr_req),
    .state  (cache_ctrl_inst.state)
);

// ==== logic/ap_data_cache.sv ====
module ap_data_cache
(
    input  logic                  clk,
    input  logic                  rst,

    input  cache_pkg::cache_cmd_t cmd,
    input  cache_pkg::row_addr_t  row_addr,
    input  cache_pkg::col_sel_t   col_sel,
    input  cache_pkg::word_t      row_wdata,
    input  cache_pkg::col_vec_t   col_wdata,
    output logic                  ready,
    output cache_pkg::word_t      row_rdata,
    output cache_pkg::col_vec_t   col_rdata,

    output logic                  rd_req,
    output cache_pkg::ddr_addr_t  rd_addr,
    input  logic                  rd_valid,
    input  cache_pkg::word_t      rd_data,
    output logic                  wr_req,
    output cache_pkg::ddr_addr_t  wr_addr,
    output cache_pkg::word_t      wr_data,
    input  logic                  wr_data_req
);

    import cache_pkg::*;

    row_idx_t row_idx;
    logic     row_we;
    logic     col_we;
    logic     fill_we;
    row_idx_t fill_idx;
    row_idx_t drain_idx;

    cache_ctrl cache_ctrl_inst
    (
        .clk         (clk),
        .rst         (rst),
        .cmd         (cmd),
        .row_addr    (row_addr),
        .ready       (ready),
        .row_idx     (row_idx),
        .row_we      (row_we),
        .col_we      (col_we),
        .fill_we     (fill_we),
        .fill_idx    (fill_idx),
        .drain_idx   (drain_idx),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .rd_valid    (rd_valid),
        .wr_req      (wr_req),
        .wr_addr     (wr_addr),
        .wr_data_req (wr_data_req)
    );

    // burst words enter and leave the buffer without extra staging.
    line_buffer line_buffer_inst
    (
        .clk        (clk),
        .rst        (rst),
        .row_idx    (row_idx),
        .row_we     (row_we),
        .row_wdata  (row_wdata),
        .col_sel    (col_sel),
        .col_we     (col_we),
        .col_wdata  (col_wdata),
        .fill_we    (fill_we),
        .fill_idx   (fill_idx),
        .fill_data  (rd_data),
        .drain_idx  (drain_idx),
        .row_rdata  (row_rdata),
        .col_rdata  (col_rdata),
        .drain_data (wr_data)
    );

endmodule

// ==== logic/cache_ctrl.sv ====
module cache_ctrl
(
    input  logic                  clk,
    input  logic                  rst,

    input  cache_pkg::cache_cmd_t cmd,
    input  cache_pkg::row_addr_t  row_addr,
    output logic                  ready,

    output cache_pkg::row_idx_t   row_idx,
    output logic                  row_we,
    output logic                  col_we,
    output logic                  fill_we,
    output cache_pkg::row_idx_t   fill_idx,
    output cache_pkg::row_idx_t   drain_idx,

    output logic                  rd_req,
    output cache_pkg::ddr_addr_t  rd_addr,
    input  logic                  rd_valid,
    output logic                  wr_req,
    output cache_pkg::ddr_addr_t  wr_addr,
    input  logic                  wr_data_req
);

    import cache_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;

    row_addr_t   tag;
    logic        valid;
    logic        dirty;

    burst_cnt_t  fill_cnt;
    burst_cnt_t  drain_cnt;

    row_addr_t   offset;
    logic        hit;
    logic        cmd_valid;
    logic        is_store;
    logic        retag;
    logic        drain_step;
    logic        fill_last;
    logic        drain_last;

    // offset into the block; only meaningful when the address is not below the tag.
    assign offset = row_addr - tag;
    assign hit    = valid && (row_addr >= tag) && (offset < row_addr_t'(BLOCK_ROWS));

    assign cmd_valid = (cmd == CMD_ROW_LOAD) || (cmd == CMD_ROW_STORE) ||
                       (cmd == CMD_COL_LOAD) || (cmd == CMD_COL_STORE) ||
                       (cmd == CMD_FLUSH);
    assign is_store  = (cmd == CMD_ROW_STORE) || (cmd == CMD_COL_STORE);

    // a clean row-store miss takes the new window without a fill.
    assign retag = (state == ST_LOOKUP) && (cmd == CMD_ROW_STORE) && !hit && !dirty;

    assign fill_we    = (state == ST_FILL_DATA) && rd_valid;
    assign drain_step = (state == ST_WB_DATA) && wr_data_req;
    assign fill_last  = fill_we && (fill_cnt == burst_cnt_t'(BLOCK_ROWS - 1));
    assign drain_last = drain_step && (drain_cnt == burst_cnt_t'(BLOCK_ROWS - 1));

    assign row_idx   = row_idx_t'(offset);
    assign fill_idx  = row_idx_t'(fill_cnt);
    assign drain_idx = row_idx_t'(drain_cnt);

    // store data goes straight to the buffer, only the strobe is issued here.
    assign row_we = (state == ST_DONE) && (cmd == CMD_ROW_STORE);
    assign col_we = (state == ST_DONE) && (cmd == CMD_COL_STORE);

    assign rd_req  = (state == ST_FILL_REQ);
    assign wr_req  = (state == ST_WB_REQ);
    assign rd_addr = ddr_addr_t'(row_addr) << DDR_ROW_SHIFT;
    // write-back always goes to the window that is still tagged.
    assign wr_addr = ddr_addr_t'(tag) << DDR_ROW_SHIFT;

    always_comb
    begin
        state_next = state;
        case (state)
            ST_IDLE:
            begin
                // the ready cycle still shows the old command.
                if (!ready && cmd_valid)
                    state_next = ST_LOOKUP;
            end
            ST_LOOKUP:
            begin
                if (cmd == CMD_FLUSH)
                    state_next = dirty ? ST_WB_REQ : ST_DONE;
                else if (hit)
                    state_next = ST_DONE;
                else if (dirty)
                    state_next = ST_WB_REQ;
                else if (cmd == CMD_ROW_STORE)
                    state_next = ST_DONE;
                else
                    state_next = ST_FILL_REQ;
            end
            ST_WB_REQ:
            begin
                state_next = ST_WB_DATA;
            end
            ST_WB_DATA:
            begin
                // after write-back the block is clean, so the lookup is redone.
                if (drain_last)
                    state_next = (cmd == CMD_FLUSH) ? ST_DONE : ST_LOOKUP;
            end
            ST_FILL_REQ:
            begin
                state_next = ST_FILL_DATA;
            end
            ST_FILL_DATA:
            begin
                if (fill_last)
                    state_next = ST_LOOKUP;
            end
            ST_DONE:
            begin
                state_next = ST_IDLE;
            end
            default:
            begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state <= ST_IDLE;
            ready <= 1'b0;
        end
        else
        begin
            state <= state_next;
            // registered so the pulse lands two cycles after the command is taken.
            ready <= (state == ST_DONE);
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            tag   <= '0;
            valid <= 1'b0;
            dirty <= 1'b0;
        end
        else
        begin
            if (retag || fill_last)
            begin
                tag   <= row_addr;
                valid <= 1'b1;
            end
            if (drain_last)
                dirty <= 1'b0;
            else if ((state == ST_DONE) && is_store)
                dirty <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            fill_cnt  <= '0;
            drain_cnt <= '0;
        end
        else
        begin
            if (state == ST_FILL_REQ)
                fill_cnt <= '0;
            else if (fill_we)
                fill_cnt <= fill_cnt + 1'b1;

            if (state == ST_WB_REQ)
                drain_cnt <= '0;
            else if (drain_step)
                drain_cnt <= drain_cnt + 1'b1;
        end
    end

endmodule

// ==== logic/line_buffer.sv ====
module line_buffer
(
    input  logic                clk,
    input  logic                rst,

    input  cache_pkg::row_idx_t row_idx,
    input  logic                row_we,
    input  cache_pkg::word_t    row_wdata,

    input  cache_pkg::col_sel_t col_sel,
    input  logic                col_we,
    input  cache_pkg::col_vec_t col_wdata,

    input  logic                fill_we,
    input  cache_pkg::row_idx_t fill_idx,
    input  cache_pkg::word_t    fill_data,

    input  cache_pkg::row_idx_t drain_idx,

    output cache_pkg::word_t    row_rdata,
    output cache_pkg::col_vec_t col_rdata,
    output cache_pkg::word_t    drain_data
);

    import cache_pkg::*;

    word_t rows [BLOCK_ROWS];

    // at most one write source is active in any cycle.
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            for (int i = 0; i < BLOCK_ROWS; i++)
            begin
                rows[i] <= '0;
            end
        end
        else if (fill_we)
        begin
            rows[fill_idx] <= fill_data;
        end
        else if (row_we)
        begin
            rows[row_idx] <= row_wdata;
        end
        else if (col_we)
        begin
            // bit j of the vector lands in row j.
            for (int j = 0; j < BLOCK_ROWS; j++)
            begin
                rows[j][col_sel] <= col_wdata[j];
            end
        end
    end

    assign row_rdata  = rows[row_idx];
    assign drain_data = rows[drain_idx];

    always_comb
    begin
        for (int j = 0; j < BLOCK_ROWS; j++)
        begin
            col_rdata[j] = rows[j][col_sel];
        end
    end

endmodule

// ==== logic/cache_pkg.sv ====
package cache_pkg;

    // geometry of the cached block.
    localparam int WORD_W        = 16;
    localparam int BLOCK_ROWS    = 16;
    localparam int ROW_ADDR_W    = 16;
    localparam int DDR_ADDR_W    = 28;
    // one processor row covers eight DDR byte lanes.
    localparam int DDR_ROW_SHIFT = 3;

    typedef logic [WORD_W-1:0]              word_t;
    typedef logic [BLOCK_ROWS-1:0]          col_vec_t;
    typedef logic [ROW_ADDR_W-1:0]          row_addr_t;
    typedef logic [DDR_ADDR_W-1:0]          ddr_addr_t;
    typedef logic [$clog2(WORD_W)-1:0]      col_sel_t;
    typedef logic [$clog2(BLOCK_ROWS)-1:0]  row_idx_t;
    // one extra bit so a burst count can reach BLOCK_ROWS.
    typedef logic [$clog2(BLOCK_ROWS):0]    burst_cnt_t;

    typedef enum logic [2:0] {
        CMD_IDLE      = 3'd0,
        CMD_ROW_LOAD  = 3'd1,
        CMD_ROW_STORE = 3'd2,
        CMD_COL_LOAD  = 3'd3,
        CMD_COL_STORE = 3'd4,
        CMD_FLUSH     = 3'd5
    } cache_cmd_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WB_REQ,
        ST_WB_DATA,
        ST_FILL_REQ,
        ST_FILL_DATA,
        ST_DONE
    } ctrl_state_t;

endpackage
